/* Makefile */
SIM = verilator
FLAGS = --binary --timing --assert
TOP = controlRomTb
FILELIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/controlRomTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlRomTb;
	import isaPkg::*;
	import ctrlPkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam opcode_t OP_UNKNOWN = 5'b11111;

	logic clk;
	logic rstN;
	instrKey_t key;
	logic brEq;
	logic brLt;
	ctrlWord_t ctrl;

	instrKey_t keyQ[$];
	logic eqQ[$];
	logic ltQ[$];
	ctrlWord_t expQ[$];
	integer seed;
	int cycles = 0;
	int cycleLimit = 0;	// Set once the table is built

	controlRom DUT (
		.clk(clk),
		.rstN(rstN),
		.key(key),
		.brEq(brEq),
		.brLt(brLt),
		.ctrl(ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("** FAIL **");
			$fatal(1, "Simulation stopped by cycle limit");
		end
	end

	function automatic instrKey_t keyOf(input logic alt, input funct3_t f3, input opcode_t op);
		instrKey_t k;
		k.altBit = alt;
		k.funct3 = f3;
		k.opcode = op;
		return k;
	endfunction

	// R and I forms write the ALU result back
	function automatic ctrlWord_t arithWord(input aluSel_t op, input logic b, input immSel_t imm);
		ctrlWord_t w;
		w = CTRL_DEFAULT;
		w.immSel = imm;
		w.regWEn = 1'b1;
		w.bSel = b;
		w.aluSel = op;
		w.wbSel = WB_ALU;
		return w;
	endfunction

	function automatic ctrlWord_t loadWord(input loadSel_t ld);
		ctrlWord_t w;
		w = CTRL_DEFAULT;
		w.immSel = IMM_I;
		w.regWEn = 1'b1;
		w.bSel = B_IMM;
		w.loadSel = ld;
		w.wbSel = WB_MEM;
		return w;
	endfunction

	function automatic ctrlWord_t storeWord(input storeSel_t st);
		ctrlWord_t w;
		w = CTRL_DEFAULT;
		w.immSel = IMM_S;
		w.bSel = B_IMM;
		w.memWrite = 1'b1;
		w.storeSel = st;
		return w;
	endfunction

	function automatic ctrlWord_t branchWord(input logic taken, input logic unsignedCmp);
		ctrlWord_t w;
		w = CTRL_DEFAULT;
		w.immSel = IMM_B;
		w.brUn = unsignedCmp;
		if (taken) begin	// Target is PC + offset
			w.pcSel = PC_ALU;
			w.aSel = A_PC;
			w.bSel = B_IMM;
		end
		return w;
	endfunction

	// JAL, JALR, LUI and AUIPC all add an immediate
	function automatic ctrlWord_t jumpUpperWord(input logic redirect, input logic a,
			input immSel_t imm, input wbSel_t wb);
		ctrlWord_t w;
		w = CTRL_DEFAULT;
		w.pcSel = redirect;
		w.immSel = imm;
		w.regWEn = 1'b1;
		w.aSel = a;
		w.bSel = B_IMM;
		w.wbSel = wb;
		return w;
	endfunction

	task automatic appendRow(input instrKey_t k, input logic eq, input logic lt,
			input ctrlWord_t exp);
		keyQ.push_back(k);
		eqQ.push_back(eq);
		ltQ.push_back(lt);
		expQ.push_back(exp);
	endtask

	task automatic randomFlagRow(input instrKey_t k, input ctrlWord_t exp);
		int r;
		r = $random(seed);
		appendRow(k, r[0], r[1], exp);
	endtask

	task automatic buildTable();
		randomFlagRow(keyOf(1'b0, 3'b000, OP_R), arithWord(ALU_ADD, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b1, 3'b000, OP_R), arithWord(ALU_SUB, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b001, OP_R), arithWord(ALU_SLL, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b010, OP_R), arithWord(ALU_SLT, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b011, OP_R), arithWord(ALU_SLTU, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b100, OP_R), arithWord(ALU_XOR, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b101, OP_R), arithWord(ALU_SRL, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b1, 3'b101, OP_R), arithWord(ALU_SRA, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b110, OP_R), arithWord(ALU_OR, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b111, OP_R), arithWord(ALU_AND, B_REG, IMM_NONE));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_I), arithWord(ALU_ADD, B_IMM, IMM_I));
		randomFlagRow(keyOf(1'b0, 3'b010, OP_I), arithWord(ALU_SLT, B_IMM, IMM_I));
		randomFlagRow(keyOf(1'b0, 3'b011, OP_I), arithWord(ALU_SLTU, B_IMM, IMM_I));
		randomFlagRow(keyOf(1'b0, 3'b100, OP_I), arithWord(ALU_XOR, B_IMM, IMM_I));
		randomFlagRow(keyOf(1'b0, 3'b110, OP_I), arithWord(ALU_OR, B_IMM, IMM_I));
		randomFlagRow(keyOf(1'b0, 3'b111, OP_I), arithWord(ALU_AND, B_IMM, IMM_I));
		randomFlagRow(keyOf(1'b0, 3'b001, OP_I), arithWord(ALU_SLL, B_IMM, IMM_SH));
		randomFlagRow(keyOf(1'b0, 3'b101, OP_I), arithWord(ALU_SRL, B_IMM, IMM_SH));
		randomFlagRow(keyOf(1'b1, 3'b101, OP_I), arithWord(ALU_SRA, B_IMM, IMM_SH));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_LOAD), loadWord(LD_B));
		randomFlagRow(keyOf(1'b0, 3'b001, OP_LOAD), loadWord(LD_H));
		randomFlagRow(keyOf(1'b0, 3'b010, OP_LOAD), loadWord(LD_W));
		randomFlagRow(keyOf(1'b0, 3'b100, OP_LOAD), loadWord(LD_BU));
		randomFlagRow(keyOf(1'b0, 3'b101, OP_LOAD), loadWord(LD_HU));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_STORE), storeWord(ST_B));
		randomFlagRow(keyOf(1'b0, 3'b001, OP_STORE), storeWord(ST_H));
		randomFlagRow(keyOf(1'b0, 3'b010, OP_STORE), storeWord(ST_W));
		appendRow(keyOf(1'b0, 3'b000, OP_BRANCH), 1'b1, 1'b0, branchWord(1'b1, 1'b0));
		appendRow(keyOf(1'b0, 3'b000, OP_BRANCH), 1'b0, 1'b1, branchWord(1'b0, 1'b0));
		appendRow(keyOf(1'b0, 3'b001, OP_BRANCH), 1'b0, 1'b0, branchWord(1'b1, 1'b0));
		appendRow(keyOf(1'b0, 3'b001, OP_BRANCH), 1'b1, 1'b0, branchWord(1'b0, 1'b0));
		appendRow(keyOf(1'b0, 3'b100, OP_BRANCH), 1'b0, 1'b1, branchWord(1'b1, 1'b0));
		appendRow(keyOf(1'b0, 3'b100, OP_BRANCH), 1'b0, 1'b0, branchWord(1'b0, 1'b0));
		appendRow(keyOf(1'b0, 3'b101, OP_BRANCH), 1'b1, 1'b0, branchWord(1'b1, 1'b0));
		appendRow(keyOf(1'b0, 3'b101, OP_BRANCH), 1'b0, 1'b1, branchWord(1'b0, 1'b0));
		appendRow(keyOf(1'b0, 3'b110, OP_BRANCH), 1'b0, 1'b1, branchWord(1'b1, 1'b1));
		appendRow(keyOf(1'b0, 3'b110, OP_BRANCH), 1'b1, 1'b0, branchWord(1'b0, 1'b1));
		appendRow(keyOf(1'b0, 3'b111, OP_BRANCH), 1'b0, 1'b0, branchWord(1'b1, 1'b1));
		appendRow(keyOf(1'b0, 3'b111, OP_BRANCH), 1'b0, 1'b1, branchWord(1'b0, 1'b1));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_JAL), jumpUpperWord(PC_ALU, A_PC, IMM_J, WB_PC));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_JALR), jumpUpperWord(PC_ALU, A_REG, IMM_I, WB_PC));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_LUI), jumpUpperWord(PC_PLUS4, A_REG, IMM_U, WB_ALU));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_AUIPC), jumpUpperWord(PC_PLUS4, A_PC, IMM_U, WB_ALU));
		randomFlagRow(keyOf(1'b0, 3'b000, OP_UNKNOWN), CTRL_DEFAULT);
		randomFlagRow(keyOf(1'b0, 3'b011, OP_LOAD), CTRL_DEFAULT);
		randomFlagRow(keyOf(1'b0, 3'b011, OP_STORE), CTRL_DEFAULT);
		appendRow(keyOf(1'b0, 3'b010, OP_BRANCH), 1'b1, 1'b1, CTRL_DEFAULT);
	endtask

	task automatic compareCtrl(input ctrlWord_t expected, input string what);
		assert (ctrl === expected) else begin
			$display("ERROR: %0d ns: %s ctrl %h, expected %h", $time, what, ctrl, expected);
			$display("** FAIL **");
			$fatal(1, "Control word mismatch");
		end
	endtask

	initial begin
		int i;
		int last;
		seed = 29;
		key = keyOf(1'b0, 3'b000, OP_UNKNOWN);	// Idle key decodes to the bubble
		brEq = 1'b0;
		brLt = 1'b0;
		rstN = 1'b0;
		buildTable();
		last = keyQ.size() - 1;
		cycleLimit = RESET_CYCLES + keyQ.size() + 10;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			compareCtrl(CTRL_DEFAULT, "during reset");
		end
		@(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		compareCtrl(CTRL_DEFAULT, "after reset");
		// New key every edge while the previous result is checked mid-cycle
		for (i = 0; i <= last; i++) begin
			@(posedge clk);
			key <= keyQ[i];
			brEq <= eqQ[i];
			brLt <= ltQ[i];
			@(negedge clk);
			if (i > 0) begin
				compareCtrl(expQ[i - 1], $sformatf("row %0d", i - 1));
			end
		end
		@(posedge clk);
		key <= keyOf(1'b0, 3'b000, OP_UNKNOWN);
		@(negedge clk);
		compareCtrl(expQ[last], $sformatf("row %0d", last));
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/mainDecoder.sv
rtl/aluOpDecoder.sv
rtl/branchResolver.sv
rtl/memAccessDecoder.sv
rtl/controlRom.sv
bench/controlRomTb.sv

/* rtl/aluOpDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluOpDecoder (
	input isaPkg::instrClass_t instrClass,
	input isaPkg::funct3_t funct3,
	input logic altBit,
	output ctrlPkg::aluSel_t aluSel
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic arith;	// R or I class

	assign arith = (instrClass == CLS_R) || (instrClass == CLS_I);

	always_comb begin
		aluSel = ALU_ADD;	// Address and link arithmetic
		if (arith) begin
			case (funct3)
				F3_ADD: begin
					// Immediate forms have no subtract
					if (instrClass == CLS_R && altBit) begin
						aluSel = ALU_SUB;
					end else begin
						aluSel = ALU_ADD;
					end
				end
				F3_SLL: aluSel = ALU_SLL;
				F3_SLT: aluSel = ALU_SLT;
				F3_SLTU: aluSel = ALU_SLTU;
				F3_XOR: aluSel = ALU_XOR;
				F3_SR: aluSel = altBit ? ALU_SRA : ALU_SRL;
				F3_OR: aluSel = ALU_OR;
				F3_AND: aluSel = ALU_AND;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/branchResolver.sv */
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
	input isaPkg::instrClass_t instrClass,
	input isaPkg::funct3_t funct3,
	input logic brEq,
	input logic brLt,
	output logic branchTaken,
	output logic brUn,
	output logic branchLegal
);
	import isaPkg::*;

	always_comb begin
		branchTaken = 1'b0;
		brUn = 1'b0;
		branchLegal = 1'b1;
		if (instrClass == CLS_BRANCH) begin
			brUn = (funct3 == F3_BLTU) || (funct3 == F3_BGEU);
			case (funct3)
				F3_BEQ: branchTaken = brEq;
				F3_BNE: branchTaken = !brEq;
				F3_BLT, F3_BLTU: branchTaken = brLt;	// brLt already reflects brUn
				F3_BGE, F3_BGEU: branchTaken = !brLt;
				default: branchLegal = 1'b0;	// 010 and 011
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/controlRom.sv */
`timescale 1ns/1ps
`default_nettype none

module controlRom (
	input logic clk,
	input logic rstN,
	input isaPkg::instrKey_t key,
	input logic brEq,
	input logic brLt,
	output ctrlPkg::ctrlWord_t ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	instrClass_t instrClass;
	immSel_t immSel;
	aluSel_t aluSel;
	loadSel_t loadSel;
	storeSel_t storeSel;
	wbSel_t wbSel;
	logic regWEn;
	logic aSel;
	logic bSel;
	logic pcSel;
	logic memWrite;
	logic memLegal;
	logic branchTaken;
	logic brUn;
	logic branchLegal;
	logic keyLegal;
	ctrlWord_t nextCtrl;

	mainDecoder uMain (
		.opcode(key.opcode),
		.funct3(key.funct3),
		.branchTaken(branchTaken),
		.instrClass(instrClass),
		.immSel(immSel),
		.regWEn(regWEn),
		.aSel(aSel),
		.bSel(bSel),
		.pcSel(pcSel),
		.wbSel(wbSel)
	);

	aluOpDecoder uAluOp (
		.instrClass(instrClass),
		.funct3(key.funct3),
		.altBit(key.altBit),
		.aluSel(aluSel)
	);

	branchResolver uBranch (
		.instrClass(instrClass),
		.funct3(key.funct3),
		.brEq(brEq),
		.brLt(brLt),
		.branchTaken(branchTaken),
		.brUn(brUn),
		.branchLegal(branchLegal)
	);

	memAccessDecoder uMem (
		.instrClass(instrClass),
		.funct3(key.funct3),
		.loadSel(loadSel),
		.storeSel(storeSel),
		.memWrite(memWrite),
		.memLegal(memLegal)
	);

	assign keyLegal = (instrClass != CLS_NONE) && memLegal && branchLegal;

	always_comb begin
		nextCtrl = CTRL_DEFAULT;	// Bubble for unknown keys
		if (keyLegal) begin
			nextCtrl.pcSel = pcSel;
			nextCtrl.immSel = immSel;
			nextCtrl.regWEn = regWEn;
			nextCtrl.aSel = aSel;
			nextCtrl.bSel = bSel;
			nextCtrl.aluSel = aluSel;
			nextCtrl.brUn = brUn;
			nextCtrl.memWrite = memWrite;
			nextCtrl.loadSel = loadSel;
			nextCtrl.storeSel = storeSel;
			nextCtrl.wbSel = wbSel;
		end
	end

	// Decode to execute stage register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ctrl <= CTRL_DEFAULT;
		end else begin
			ctrl <= nextCtrl;
		end
	end

	noStoreWriteback: assert property (@(posedge clk) disable iff (!rstN)
		!(ctrl.memWrite && ctrl.regWEn))
		else $error("memWrite and regWEn both set");

	wbSelEncoding: assert property (@(posedge clk) disable iff (!rstN)
		ctrl.wbSel != 2'b11)
		else $error("wbSel holds reserved code");

	// Redirect needs a PC-relative target unless the word is JALR
	redirectSource: assert property (@(posedge clk) disable iff (!rstN)
		(ctrl.pcSel == PC_ALU) |-> (ctrl.aSel == A_PC ||
			(ctrl.wbSel == WB_PC && ctrl.immSel == IMM_I)))
		else $error("PC_ALU without PC operand or JALR word");

endmodule

`default_nettype wire

/* rtl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

	typedef logic [2:0] immSel_t;
	typedef logic [3:0] aluSel_t;
	typedef logic [2:0] loadSel_t;
	typedef logic [1:0] storeSel_t;
	typedef logic [1:0] wbSel_t;

	// Immediate formats
	localparam immSel_t IMM_NONE = 3'b000;
	localparam immSel_t IMM_U = 3'b001;
	localparam immSel_t IMM_I = 3'b010;
	localparam immSel_t IMM_SH = 3'b011;	// 5-bit shift amount
	localparam immSel_t IMM_B = 3'b100;
	localparam immSel_t IMM_S = 3'b101;
	localparam immSel_t IMM_J = 3'b110;

	localparam aluSel_t ALU_ADD = 4'b0000;
	localparam aluSel_t ALU_SUB = 4'b0001;
	localparam aluSel_t ALU_AND = 4'b0010;
	localparam aluSel_t ALU_OR = 4'b0011;
	localparam aluSel_t ALU_XOR = 4'b0100;
	localparam aluSel_t ALU_SLL = 4'b0101;
	localparam aluSel_t ALU_SRL = 4'b0110;
	localparam aluSel_t ALU_SRA = 4'b0111;
	localparam aluSel_t ALU_SLT = 4'b1001;
	localparam aluSel_t ALU_SLTU = 4'b1010;

	localparam loadSel_t LD_W = 3'b000;
	localparam loadSel_t LD_H = 3'b001;
	localparam loadSel_t LD_B = 3'b010;
	localparam loadSel_t LD_HU = 3'b011;
	localparam loadSel_t LD_BU = 3'b100;

	localparam storeSel_t ST_W = 2'b00;
	localparam storeSel_t ST_H = 2'b01;
	localparam storeSel_t ST_B = 2'b10;

	localparam wbSel_t WB_MEM = 2'b00;
	localparam wbSel_t WB_ALU = 2'b01;
	localparam wbSel_t WB_PC = 2'b10;

	localparam logic PC_PLUS4 = 1'b0;
	localparam logic PC_ALU = 1'b1;	// Jump or taken branch target
	localparam logic A_REG = 1'b0;
	localparam logic A_PC = 1'b1;
	localparam logic B_REG = 1'b0;
	localparam logic B_IMM = 1'b1;

	typedef struct packed {
		logic pcSel;
		immSel_t immSel;
		logic regWEn;
		logic aSel;
		logic bSel;
		aluSel_t aluSel;
		logic brUn;	// Unsigned compare request
		logic memWrite;
		loadSel_t loadSel;
		storeSel_t storeSel;
		wbSel_t wbSel;
	} ctrlWord_t;

	// Bubble word with no side effects and sequential PC
	localparam ctrlWord_t CTRL_DEFAULT = '0;

endpackage

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

	typedef logic [4:0] opcode_t;	// Instruction bits 6:2
	typedef logic [2:0] funct3_t;
	typedef logic [3:0] instrClass_t;

	typedef struct packed {
		logic altBit;	// funct7 bit 5
		funct3_t funct3;
		opcode_t opcode;
	} instrKey_t;

	localparam opcode_t OP_R = 5'b01100;
	localparam opcode_t OP_I = 5'b00100;
	localparam opcode_t OP_LOAD = 5'b00000;
	localparam opcode_t OP_STORE = 5'b01000;
	localparam opcode_t OP_BRANCH = 5'b11000;
	localparam opcode_t OP_JAL = 5'b11011;
	localparam opcode_t OP_JALR = 5'b11001;
	localparam opcode_t OP_LUI = 5'b01101;
	localparam opcode_t OP_AUIPC = 5'b00101;

	// Arithmetic and logic group shared by R and I
	localparam funct3_t F3_ADD = 3'b000;
	localparam funct3_t F3_SLL = 3'b001;
	localparam funct3_t F3_SLT = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_SR = 3'b101;	// SRL or SRA by altBit
	localparam funct3_t F3_OR = 3'b110;
	localparam funct3_t F3_AND = 3'b111;

	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;
	localparam funct3_t F3_BLT = 3'b100;
	localparam funct3_t F3_BGE = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_B = 3'b000;	// Byte access for load or store
	localparam funct3_t F3_H = 3'b001;
	localparam funct3_t F3_W = 3'b010;
	localparam funct3_t F3_BU = 3'b100;
	localparam funct3_t F3_HU = 3'b101;

	localparam instrClass_t CLS_NONE = 4'd0;
	localparam instrClass_t CLS_R = 4'd1;
	localparam instrClass_t CLS_I = 4'd2;
	localparam instrClass_t CLS_LOAD = 4'd3;
	localparam instrClass_t CLS_STORE = 4'd4;
	localparam instrClass_t CLS_BRANCH = 4'd5;
	localparam instrClass_t CLS_JAL = 4'd6;
	localparam instrClass_t CLS_JALR = 4'd7;
	localparam instrClass_t CLS_LUI = 4'd8;
	localparam instrClass_t CLS_AUIPC = 4'd9;

endpackage

`default_nettype wire

/* rtl/mainDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
	input isaPkg::opcode_t opcode,
	input isaPkg::funct3_t funct3,
	input logic branchTaken,
	output isaPkg::instrClass_t instrClass,
	output ctrlPkg::immSel_t immSel,
	output logic regWEn,
	output logic aSel,
	output logic bSel,
	output logic pcSel,
	output ctrlPkg::wbSel_t wbSel
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		instrClass = CLS_NONE;
		immSel = IMM_NONE;
		regWEn = 1'b0;
		aSel = A_REG;
		bSel = B_REG;
		pcSel = PC_PLUS4;
		wbSel = WB_MEM;
		case (opcode)
			OP_R: begin
				instrClass = CLS_R;
				regWEn = 1'b1;
				wbSel = WB_ALU;
			end
			OP_I: begin
				instrClass = CLS_I;
				immSel = (funct3 == F3_SLL || funct3 == F3_SR) ? IMM_SH : IMM_I;
				regWEn = 1'b1;
				bSel = B_IMM;
				wbSel = WB_ALU;
			end
			OP_LOAD: begin
				instrClass = CLS_LOAD;
				immSel = IMM_I;
				regWEn = 1'b1;
				bSel = B_IMM;
			end
			OP_STORE: begin
				instrClass = CLS_STORE;
				immSel = IMM_S;
				bSel = B_IMM;
			end
			OP_BRANCH: begin
				instrClass = CLS_BRANCH;
				immSel = IMM_B;
				if (branchTaken) begin	// ALU forms PC + offset
					aSel = A_PC;
					bSel = B_IMM;
					pcSel = PC_ALU;
				end
			end
			OP_JAL: begin
				instrClass = CLS_JAL;
				immSel = IMM_J;
				regWEn = 1'b1;
				aSel = A_PC;
				bSel = B_IMM;
				pcSel = PC_ALU;
				wbSel = WB_PC;	// Link address
			end
			OP_JALR: begin
				instrClass = CLS_JALR;
				immSel = IMM_I;
				regWEn = 1'b1;
				bSel = B_IMM;
				pcSel = PC_ALU;
				wbSel = WB_PC;
			end
			OP_LUI: begin
				instrClass = CLS_LUI;
				immSel = IMM_U;
				regWEn = 1'b1;
				bSel = B_IMM;
				wbSel = WB_ALU;
			end
			OP_AUIPC: begin
				instrClass = CLS_AUIPC;
				immSel = IMM_U;
				regWEn = 1'b1;
				aSel = A_PC;
				bSel = B_IMM;
				wbSel = WB_ALU;
			end
			default: ;	// Unknown opcode keeps the bubble
		endcase
	end

endmodule

`default_nettype wire

/* rtl/memAccessDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module memAccessDecoder (
	input isaPkg::instrClass_t instrClass,
	input isaPkg::funct3_t funct3,
	output ctrlPkg::loadSel_t loadSel,
	output ctrlPkg::storeSel_t storeSel,
	output logic memWrite,
	output logic memLegal
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		loadSel = LD_W;
		storeSel = ST_W;
		memWrite = 1'b0;
		memLegal = 1'b1;
		if (instrClass == CLS_LOAD) begin
			case (funct3)
				F3_B: loadSel = LD_B;
				F3_H: loadSel = LD_H;
				F3_W: loadSel = LD_W;
				F3_BU: loadSel = LD_BU;
				F3_HU: loadSel = LD_HU;
				default: memLegal = 1'b0;
			endcase
		end else if (instrClass == CLS_STORE) begin
			memWrite = 1'b1;
			case (funct3)
				F3_B: storeSel = ST_B;
				F3_H: storeSel = ST_H;
				F3_W: storeSel = ST_W;
				default: begin
					memWrite = 1'b0;	// Never write on a bad width
					memLegal = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire
